// File: vlog.f
+incdir+src
src/sched_pkg.sv
src/slot_keeper.sv
src/desc_allocator.sv
src/port_desc_fsm.sv
src/host_cmd_regs.sv
src/sched_top.sv
sim/sched_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal --top-module sched_tb -f vlog.f -o sched_sim
./obj_dir/sched_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0

// File: sim/sched_tb.sv
// ----------------------------------------
// Self-checking testbench for sched_top with host,
// slot command, dispatch and contention phases
// ----------------------------------------
`include "sched_defs.svh"

module sched_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import sched_pkg::*;

  localparam int IF_N   = `SCHED_IF_COUNT;
  localparam int CORE_N = `SCHED_CORE_COUNT;

  logic       clk;
  logic       rst_r;
  data_t      rx_tdata [IF_N];
  keep_t      rx_tkeep [IF_N];
  port_mask_t rx_tvalid, rx_tlast, rx_tready;
  data_t      data_m_tdata [IF_N];
  keep_t      data_m_tkeep [IF_N];
  desc_t      data_m_tdest [IF_N];
  port_id_t   data_m_tuser [IF_N];
  port_mask_t data_m_tvalid, data_m_tlast, data_m_tready;
  ctrl_t      ctrl_s_tdata;
  logic       ctrl_s_tvalid;
  core_id_t   ctrl_s_tuser;
  host_word_t host_cmd, host_cmd_wr_data, host_cmd_rd_data;
  logic       host_cmd_valid;
  logic       slot_err;

  // Per-port driver outputs with one process each
  logic drv_valid [IF_N];
  logic drv_last [IF_N];
  logic drv_done [IF_N];

  // Reference model of the masks and slot FIFOs
  core_mask_t enabled_m, income_m;
  slot_t      model_q [CORE_N][$];

  data_t exp_data [IF_N][$];
  keep_t exp_keep [IF_N][$];
  logic  exp_last [IF_N][$];
  desc_t exp_desc [IF_N][$];
  logic  exact_desc;
  logic  in_pkt [IF_N];
  desc_t pkt_desc [IF_N];
  bit    used_desc [desc_t];
  desc_t ret_q [$];
  desc_t ret_d;
  desc_t d0, d1;
  int    err_count, tmo_count, idle;

  assign rx_tvalid = {drv_valid[1], drv_valid[0]};
  assign rx_tlast  = {drv_last[1], drv_last[0]};

  sched_top sched_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #2000000;
    $display("watchdog expired before the test sequence finished");
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_word(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_keep(input string name, input keep_t got, input keep_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_desc(input string name, input desc_t got, input desc_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_port(input string name, input port_id_t got, input port_id_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_mask(input string name, input port_mask_t got,
                            input port_mask_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_host(input string name, input host_word_t got, input host_word_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  // Eligible core with the most slots and the lower index winning a tie
  function automatic int pick_core();
    int best;
    best = -1;
    for (int c = 0; c < CORE_N; c++) begin
      if (enabled_m[c] && income_m[c] && model_q[c].size() > 0 &&
          (best < 0 || model_q[c].size() > model_q[best].size()))
        best = c;
    end
    return best;
  endfunction

  function automatic desc_t alloc_next();
    int    c;
    slot_t s;
    c = pick_core();
    s = model_q[c].pop_front();
    return desc_t'((c << `SCHED_TAG_WIDTH) | int'(s));
  endfunction

  function automatic host_word_t exp_read(input logic [3:0] code, input int core);
    case (code)
      `SCHED_REG_ENABLE: return host_word_t'(enabled_m);
      `SCHED_REG_INCOME: return host_word_t'(income_m);
      `SCHED_REG_COUNT:  return host_word_t'(model_q[core].size());
      default:           return `SCHED_RD_DEFAULT;
    endcase
  endfunction

  task automatic reset_dut();
    rst_r = 1'b1;
    for (int p = 0; p < IF_N; p++) begin
      drv_valid[p] = 1'b0;
      drv_last[p]  = 1'b0;
      drv_done[p]  = 1'b0;
      rx_tdata[p]  = '0;
      rx_tkeep[p]  = '0;
      in_pkt[p]    = 1'b0;
      exp_desc[p].delete();
    end
    data_m_tready    = '1;
    ctrl_s_tdata     = '0;
    ctrl_s_tvalid    = 1'b0;
    ctrl_s_tuser     = '0;
    host_cmd         = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid   = 1'b0;
    enabled_m        = '0;
    income_m         = '0;
    for (int c = 0; c < CORE_N; c++)
      model_q[c].delete();
    used_desc.delete();
    repeat (2) @(negedge clk);
    rst_r = 1'b0;
  endtask

  task automatic send_ctrl(input logic [3:0] typ, input int core, input slot_t slot);
    @(negedge clk);
    ctrl_s_tdata = '0;
    ctrl_s_tdata[35:32] = typ;
    ctrl_s_tdata[16 +: $bits(slot_t)] = slot;
    ctrl_s_tuser  = core_id_t'(core);
    ctrl_s_tvalid = 1'b1;
    @(negedge clk);
    ctrl_s_tvalid = 1'b0;
  endtask

  task automatic init_core(input int core, input int n);
    send_ctrl(`SCHED_MSG_SLOT_INIT, core, slot_t'(n));
    model_q[core].delete();
    for (int i = 1; i <= n; i++)
      model_q[core].push_back(slot_t'(i));
  endtask

  task automatic host_write(input logic [3:0] code, input core_mask_t data);
    @(negedge clk);
    host_cmd         = 32'hA000_0000 | host_word_t'(code);
    host_cmd_wr_data = host_word_t'(data);
    host_cmd_valid   = 1'b1;
    @(negedge clk);
    host_cmd_valid = 1'b0;
    host_cmd       = '0;
    repeat (2) @(negedge clk);
    case (code)
      `SCHED_REG_ENABLE: begin
        enabled_m = data;
        income_m  = income_m & data;
      end
      `SCHED_REG_INCOME: income_m = data & enabled_m;
      `SCHED_REG_FLUSH: begin
        for (int c = 0; c < CORE_N; c++)
          if (data[c])
            model_q[c].delete();
      end
      default: ;
    endcase
  endtask

  // Readback is valid two cycles after the command
  task automatic host_read(input logic [3:0] code, input int core);
    @(negedge clk);
    host_cmd       = 32'h2000_0000 | host_word_t'(core << 4) | host_word_t'(code);
    host_cmd_valid = 1'b0;
    repeat (2) @(negedge clk);
    check_host("host_cmd_rd_data", host_cmd_rd_data, exp_read(code, core));
  endtask

  task automatic send_packet(input int p, input int len);
    data_t w;
    keep_t k;
    int    t;
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      w = {$urandom, $urandom};
      k = keep_t'($urandom);
      rx_tdata[p]  = w;
      rx_tkeep[p]  = k;
      drv_last[p]  = (i == len - 1);
      drv_valid[p] = 1'b1;
      exp_data[p].push_back(w);
      exp_keep[p].push_back(k);
      exp_last[p].push_back(i == len - 1);
      t = 0;
      do begin
        @(posedge clk);
        t++;
      end while (!rx_tready[p] && t < 400);
      if (!rx_tready[p]) begin
        $display("timeout at %0t: port %0d never accepted a word", $time, p);
        tmo_count++;
      end
    end
    @(negedge clk);
    drv_valid[p] = 1'b0;
    drv_last[p]  = 1'b0;
  endtask

  // Output monitor that checks every accepted word
  always @(posedge clk) begin
    if (!rst_r) begin
      for (int p = 0; p < IF_N; p++) begin
        if (data_m_tvalid[p] && data_m_tready[p]) begin
          if (exp_data[p].size() == 0) begin
            $display("unexpected word on port %0d at %0t", p, $time);
            err_count++;
          end else begin
            check_word("data_m_tdata", data_m_tdata[p], exp_data[p].pop_front());
            check_keep("data_m_tkeep", data_m_tkeep[p], exp_keep[p].pop_front());
            check_flag("data_m_tlast", data_m_tlast[p], exp_last[p].pop_front());
          end
          check_port("data_m_tuser", data_m_tuser[p], port_id_t'(p));
          if (!in_pkt[p]) begin
            if (exact_desc) begin
              if (exp_desc[p].size() == 0) begin
                $display("packet on port %0d at %0t has no expected tdest", p, $time);
                err_count++;
              end else begin
                check_desc("data_m_tdest", data_m_tdest[p], exp_desc[p].pop_front());
              end
            end else if (used_desc.exists(data_m_tdest[p])) begin
              $display("slot %h given out twice at %0t", data_m_tdest[p], $time);
              err_count++;
            end else begin
              used_desc[data_m_tdest[p]] = 1'b1;
            end
            pkt_desc[p] = data_m_tdest[p];
            in_pkt[p]   = 1'b1;
          end else begin
            check_desc("data_m_tdest", data_m_tdest[p], pkt_desc[p]);
          end
          if (data_m_tlast[p]) begin
            in_pkt[p] = 1'b0;
            if (!exact_desc)
              ret_q.push_back(pkt_desc[p]);
          end
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h3d10aa95));
    err_count  = 0;
    tmo_count  = 0;
    exact_desc = 1'b1;
    rst_r      = 1'b1;
    reset_dut();

    // After reset
    drv_valid[0] = 1'b1;
    drv_valid[1] = 1'b1;
    @(negedge clk);
    check_mask("rx_tready", rx_tready, '0);
    check_mask("data_m_tvalid", data_m_tvalid, '0);
    drv_valid[0] = 1'b0;
    drv_valid[1] = 1'b0;
    host_read(`SCHED_REG_ENABLE, 0);
    host_read(`SCHED_REG_INCOME, 0);
    for (int c = 0; c < CORE_N; c++)
      host_read(`SCHED_REG_COUNT, c);

    // Host register masking
    host_write(`SCHED_REG_INCOME, 4'b0011);
    host_read(`SCHED_REG_INCOME, 0);
    host_write(`SCHED_REG_ENABLE, 4'b0101);
    host_write(`SCHED_REG_INCOME, 4'b0111);
    host_read(`SCHED_REG_INCOME, 0);
    host_write(`SCHED_REG_ENABLE, 4'b0100);
    host_read(`SCHED_REG_ENABLE, 0);
    host_read(`SCHED_REG_INCOME, 0);
    host_read(4'd7, 0);
    host_read(`SCHED_REG_FLUSH, 0);

    // Slot commands, full keeper and flush
    reset_dut();
    init_core(1, 6);
    host_read(`SCHED_REG_COUNT, 1);
    send_ctrl(`SCHED_MSG_SLOT_ENQ, 1, 4'd7);
    model_q[1].push_back(4'd7);
    send_ctrl(`SCHED_MSG_SLOT_ENQ, 1, 4'd8);
    model_q[1].push_back(4'd8);
    host_read(`SCHED_REG_COUNT, 1);
    check_flag("slot_err", slot_err, 1'b0);
    send_ctrl(`SCHED_MSG_SLOT_ENQ, 1, 4'd3);
    idle = 0;
    while (!slot_err && idle < 6) begin
      @(negedge clk);
      idle++;
    end
    if (!slot_err) begin
      $display("slot_err never rose after an enqueue into a full keeper");
      tmo_count++;
    end
    host_read(`SCHED_REG_COUNT, 1);
    host_write(`SCHED_REG_FLUSH, 4'b0010);
    host_read(`SCHED_REG_COUNT, 1);

    // Dispatch on port 0 while port 1 holds one reserved descriptor
    reset_dut();
    init_core(0, 3);
    init_core(1, 5);
    init_core(2, 4);
    init_core(3, 2);
    host_write(`SCHED_REG_ENABLE, 4'b1111);
    host_write(`SCHED_REG_INCOME, 4'b0111);
    d0 = alloc_next();
    d1 = alloc_next();
    for (int k = 0; k < 5; k++) begin
      exp_desc[0].push_back(d0);
      d0 = alloc_next();
    end
    for (int k = 0; k < 5; k++)
      send_packet(0, 1 + $urandom % 4);
    for (int c = 0; c < CORE_N; c++)
      host_read(`SCHED_REG_COUNT, c);
    if (exp_data[0].size() != 0 || exp_desc[0].size() != 0) begin
      $display("port 0 lost words or packets in the dispatch phase");
      err_count++;
    end

    // Contention with random back-pressure and slot returns
    reset_dut();
    exact_desc = 1'b0;
    for (int c = 0; c < CORE_N; c++)
      init_core(c, `SCHED_SLOT_COUNT);
    host_write(`SCHED_REG_ENABLE, 4'b1111);
    host_write(`SCHED_REG_INCOME, 4'b1111);
    fork
      begin
        for (int k = 0; k < 10; k++)
          send_packet(0, 1 + $urandom % 4);
        drv_done[0] = 1'b1;
      end
      begin
        for (int k = 0; k < 10; k++)
          send_packet(1, 1 + $urandom % 4);
        drv_done[1] = 1'b1;
      end
      begin
        while (!(drv_done[0] && drv_done[1])) begin
          @(negedge clk);
          data_m_tready = {($urandom % 4) != 0, ($urandom % 4) != 0};
        end
        data_m_tready = '1;
      end
      begin
        idle = 0;
        while (!(drv_done[0] && drv_done[1] && ret_q.size() == 0) && idle < 4000) begin
          if (ret_q.size() > 0) begin
            ret_d = ret_q.pop_front();
            used_desc.delete(ret_d);
            send_ctrl(`SCHED_MSG_SLOT_ENQ, int'(ret_d[6:5]), ret_d[3:0]);
          end else begin
            @(negedge clk);
            idle++;
          end
        end
        if (idle >= 4000) begin
          $display("contention phase did not drain in time");
          tmo_count++;
        end
      end
    join
    for (int p = 0; p < IF_N; p++) begin
      if (exp_data[p].size() != 0) begin
        $display("port %0d lost %0d words under contention", p, exp_data[p].size());
        err_count++;
      end
    end

    // Starvation until a slot is returned
    reset_dut();
    exact_desc = 1'b1;
    host_write(`SCHED_REG_ENABLE, 4'b0011);
    host_write(`SCHED_REG_INCOME, 4'b0011);
    fork
      send_packet(0, 2);
      begin
        repeat (20) begin
          @(negedge clk);
          check_flag("rx_tready", rx_tready[0], 1'b0);
        end
        model_q[1].push_back(4'd6);
        exp_desc[0].push_back(alloc_next());
        send_ctrl(`SCHED_MSG_SLOT_ENQ, 1, 4'd6);
      end
    join
    repeat (2) @(negedge clk);
    if (exp_data[0].size() != 0 || exp_desc[0].size() != 0) begin
      $display("waiting packet did not leave after the slot return");
      err_count++;
    end
    host_read(`SCHED_REG_COUNT, 1);

    $display("errors: %0d value, %0d timeout", err_count, tmo_count);
    if (err_count == 0 && tmo_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: src/sched_top.sv
// ----------------------------------------
// Receive-side packet scheduler top; tags each
// rx packet with a reserved (core, slot) tdest
// ----------------------------------------
`include "sched_defs.svh"

module sched_top (
  input  logic                  clk,
  input  logic                  rst_r,
  input  sched_pkg::data_t      rx_tdata [`SCHED_IF_COUNT],
  input  sched_pkg::keep_t      rx_tkeep [`SCHED_IF_COUNT],
  input  sched_pkg::port_mask_t rx_tvalid,
  input  sched_pkg::port_mask_t rx_tlast,
  output sched_pkg::port_mask_t rx_tready,
  output sched_pkg::data_t      data_m_tdata [`SCHED_IF_COUNT],
  output sched_pkg::keep_t      data_m_tkeep [`SCHED_IF_COUNT],
  output sched_pkg::desc_t      data_m_tdest [`SCHED_IF_COUNT],
  output sched_pkg::port_id_t   data_m_tuser [`SCHED_IF_COUNT],
  output sched_pkg::port_mask_t data_m_tvalid,
  output sched_pkg::port_mask_t data_m_tlast,
  input  sched_pkg::port_mask_t data_m_tready,
  input  sched_pkg::ctrl_t      ctrl_s_tdata,
  input  logic                  ctrl_s_tvalid,
  input  sched_pkg::core_id_t   ctrl_s_tuser,
  input  sched_pkg::host_word_t host_cmd,
  input  sched_pkg::host_word_t host_cmd_wr_data,
  input  logic                  host_cmd_valid,
  output sched_pkg::host_word_t host_cmd_rd_data,
  output logic                  slot_err
);
  import sched_pkg::*;

  localparam int IF_N     = `SCHED_IF_COUNT;
  localparam int CORE_N   = `SCHED_CORE_COUNT;
  localparam int MSG_LSB  = 32;
  localparam int SLOT_LSB = 16;

  logic [`SCHED_CTRL_WIDTH-MSG_LSB-1:0] msg_type;
  slot_t      ctrl_slot_r;
  core_mask_t enq_v, init_v, enq_err, slot_valid, slot_pop, eligible;
  core_mask_t enabled_cores, income_cores, slots_flush;
  slot_t      slot_counts [CORE_N];
  slot_t      head_slots [CORE_N];
  port_mask_t desc_req, desc_grant, not_stall, word_valid;
  desc_t      alloc_desc;

  assign msg_type = ctrl_s_tdata[`SCHED_CTRL_WIDTH-1:MSG_LSB];

  always_ff @(posedge clk)
    ctrl_slot_r <= ctrl_s_tdata[SLOT_LSB +: $bits(slot_t)];

  // Slot returns and inits become per-core strobes
  always_ff @(posedge clk) begin
    if (rst_r) begin
      enq_v    <= '0;
      init_v   <= '0;
      slot_err <= 1'b0;
    end else begin
      for (int c = 0; c < CORE_N; c++) begin
        enq_v[c]  <= ctrl_s_tvalid && (msg_type == `SCHED_MSG_SLOT_ENQ) &&
                     (ctrl_s_tuser == core_id_t'(c));
        init_v[c] <= ctrl_s_tvalid && (msg_type == `SCHED_MSG_SLOT_INIT) &&
                     (ctrl_s_tuser == core_id_t'(c));
      end
      slot_err <= |enq_err;
    end
  end

  host_cmd_regs host_cmd_regs_i (
    .clk(clk), .rst_r(rst_r),
    .host_cmd(host_cmd), .host_cmd_wr_data(host_cmd_wr_data),
    .host_cmd_valid(host_cmd_valid), .host_cmd_rd_data(host_cmd_rd_data),
    .slot_counts(slot_counts), .enabled_cores(enabled_cores),
    .income_cores(income_cores), .slots_flush(slots_flush)
  );

  for (genvar c = 0; c < CORE_N; c++) begin : g_core
    slot_keeper slot_keeper_i (
      .clk(clk), .rst_r(rst_r), .flush(slots_flush[c]),
      .init_count(ctrl_slot_r), .init_valid(init_v[c]),
      .slot_in(ctrl_slot_r), .slot_in_valid(enq_v[c]),
      .slot_out(head_slots[c]), .slot_out_valid(slot_valid[c]),
      .slot_pop(slot_pop[c]), .slot_count(slot_counts[c]), .enq_err(enq_err[c])
    );
  end

  // Cores that can take a new packet right now
  assign eligible = enabled_cores & income_cores & slot_valid;

  desc_allocator desc_allocator_i (
    .clk(clk), .rst_r(rst_r), .desc_req(desc_req),
    .slot_counts(slot_counts), .head_slots(head_slots), .eligible(eligible),
    .desc_grant(desc_grant), .desc(alloc_desc), .slot_pop(slot_pop)
  );

  for (genvar p = 0; p < IF_N; p++) begin : g_port
    assign word_valid[p]    = rx_tvalid[p] && rx_tready[p];
    assign rx_tready[p]     = data_m_tready[p] && not_stall[p];
    assign data_m_tvalid[p] = rx_tvalid[p] && not_stall[p];
    assign data_m_tlast[p]  = rx_tlast[p];
    assign data_m_tdata[p]  = rx_tdata[p];
    assign data_m_tkeep[p]  = rx_tkeep[p];
    assign data_m_tuser[p]  = port_id_t'(p);

    port_desc_fsm port_desc_fsm_i (
      .clk(clk), .rst_r(rst_r), .desc_grant(desc_grant[p]), .desc(alloc_desc),
      .word_valid(word_valid[p]), .word_last(rx_tlast[p]),
      .not_stall(not_stall[p]), .desc_req(desc_req[p]), .tdest(data_m_tdest[p])
    );
  end

endmodule

// File: src/host_cmd_regs.sv
// ----------------------------------------
// Host command decode for the core masks,
// slot flush pulses and register readback
// ----------------------------------------
`include "sched_defs.svh"

module host_cmd_regs (
  input  logic                  clk,
  input  logic                  rst_r,
  input  sched_pkg::host_word_t host_cmd,
  input  sched_pkg::host_word_t host_cmd_wr_data,
  input  logic                  host_cmd_valid,
  output sched_pkg::host_word_t host_cmd_rd_data,
  input  sched_pkg::slot_t      slot_counts [`SCHED_CORE_COUNT],
  output sched_pkg::core_mask_t enabled_cores,
  output sched_pkg::core_mask_t income_cores,
  output sched_pkg::core_mask_t slots_flush
);
  import sched_pkg::*;

  localparam int CORE_W = $bits(core_id_t);

  logic       wr_r;
  logic [3:0] reg_r;
  core_id_t   rd_core_r;
  core_mask_t wr_mask_r;

  // First stage holds the command fields
  always_ff @(posedge clk) begin
    reg_r     <= host_cmd[3:0];
    rd_core_r <= host_cmd[CORE_W+3:4];
    wr_mask_r <= host_cmd_wr_data[`SCHED_CORE_COUNT-1:0];
  end

  // Bit 31 is write and bit 29 selects the scheduler
  always_ff @(posedge clk) begin
    if (rst_r)
      wr_r <= 1'b0;
    else
      wr_r <= host_cmd_valid && host_cmd[31] && host_cmd[29];
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
    end else begin
      slots_flush <= '0;
      if (wr_r) begin
        case (reg_r)
          `SCHED_REG_ENABLE: begin
            // A disabled core cannot stay incoming
            enabled_cores <= wr_mask_r;
            income_cores  <= income_cores & wr_mask_r;
          end
          `SCHED_REG_INCOME: income_cores <= wr_mask_r & enabled_cores;
          `SCHED_REG_FLUSH:  slots_flush  <= wr_mask_r;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    case (reg_r)
      `SCHED_REG_ENABLE: host_cmd_rd_data <= host_word_t'(enabled_cores);
      `SCHED_REG_INCOME: host_cmd_rd_data <= host_word_t'(income_cores);
      `SCHED_REG_COUNT:  host_cmd_rd_data <= host_word_t'(slot_counts[rd_core_r]);
      default:           host_cmd_rd_data <= `SCHED_RD_DEFAULT;
    endcase
  end

  a_income_enabled: assert property (@(posedge clk) disable iff (rst_r)
    (income_cores & ~enabled_cores) == '0);

endmodule

// File: src/port_desc_fsm.sv
// ----------------------------------------
// Per receive port descriptor tracking; holds the
// stream off until a descriptor is reserved
// ----------------------------------------
`include "sched_defs.svh"

module port_desc_fsm (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             desc_grant,
  input  sched_pkg::desc_t desc,
  input  logic             word_valid,
  input  logic             word_last,
  output logic             not_stall,
  output logic             desc_req,
  output sched_pkg::desc_t tdest
);
  import sched_pkg::*;

  port_state_t state;
  port_state_t state_next;
  // Reserved for the next packet
  desc_t       next_desc;
  // In use by the packet on the wire
  desc_t       cur_desc;

  always_comb begin
    state_next = state;
    case (state)
      st_stall: begin
        if (desc_grant)
          state_next = st_first;
      end
      st_first: begin
        if (word_valid && word_last)
          state_next = desc_grant ? st_first : st_stall;
        else if (word_valid)
          state_next = desc_grant ? st_mid : st_wait_desc;
      end
      st_wait_desc: begin
        if (word_valid && word_last)
          state_next = desc_grant ? st_first : st_stall;
        else if (desc_grant)
          state_next = st_mid;
      end
      st_mid: begin
        if (word_valid && word_last)
          state_next = st_first;
      end
      default: state_next = st_stall;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_r)
      state <= st_stall;
    else
      state <= state_next;
  end

  always_ff @(posedge clk) begin
    if (desc_grant)
      next_desc <= desc;
    // Packet start consumes the reserved descriptor
    if (state == st_first && word_valid)
      cur_desc <= next_desc;
  end

  // Ask again as soon as a packet starts
  assign desc_req  = (state == st_stall) || (state == st_wait_desc) ||
                     (state == st_first && word_valid);
  assign not_stall = (state != st_stall);
  assign tdest     = (state == st_first) ? next_desc : cur_desc;

  a_tdest_hold: assert property (@(posedge clk) disable iff (rst_r)
    (word_valid && !word_last) |=> (tdest == $past(tdest)));

endmodule

// File: src/desc_allocator.sv
// ----------------------------------------
// Picks one requesting port by round robin and
// hands it a descriptor from the fullest core
// ----------------------------------------
`include "sched_defs.svh"

module desc_allocator (
  input  logic                  clk,
  input  logic                  rst_r,
  input  sched_pkg::port_mask_t desc_req,
  input  sched_pkg::slot_t      slot_counts [`SCHED_CORE_COUNT],
  input  sched_pkg::slot_t      head_slots [`SCHED_CORE_COUNT],
  input  sched_pkg::core_mask_t eligible,
  output sched_pkg::port_mask_t desc_grant,
  output sched_pkg::desc_t      desc,
  output sched_pkg::core_mask_t slot_pop
);
  import sched_pkg::*;

  localparam int IF_N   = `SCHED_IF_COUNT;
  localparam int CORE_N = `SCHED_CORE_COUNT;
  localparam int PAD_W  = `SCHED_TAG_WIDTH - $bits(slot_t);

  port_id_t rr_ptr;
  port_id_t grant_port;
  logic     port_found;
  core_id_t best_core;
  slot_t    best_count;
  logic     core_found;
  logic     grant_valid;

  // Most free slots wins and ties go to the lower core
  always_comb begin
    core_found = 1'b0;
    best_core  = '0;
    best_count = '0;
    for (int c = 0; c < CORE_N; c++) begin
      if (eligible[c] && (!core_found || slot_counts[c] > best_count)) begin
        core_found = 1'b1;
        best_core  = core_id_t'(c);
        best_count = slot_counts[c];
      end
    end
  end

  // Scan from the far end so the port nearest rr_ptr is kept
  always_comb begin
    int idx;
    port_found = 1'b0;
    grant_port = rr_ptr;
    for (int k = IF_N - 1; k >= 0; k--) begin
      idx = (int'(rr_ptr) + k) % IF_N;
      if (desc_req[idx]) begin
        port_found = 1'b1;
        grant_port = port_id_t'(idx);
      end
    end
  end

  assign grant_valid = port_found && core_found;
  assign desc_grant  = grant_valid ? port_mask_t'(1) << grant_port : '0;
  assign slot_pop    = grant_valid ? core_mask_t'(1) << best_core : '0;
  assign desc        = {best_core, {PAD_W{1'b0}}, head_slots[best_core]};

  always_ff @(posedge clk) begin
    if (rst_r)
      rr_ptr <= '0;
    else if (grant_valid)
      rr_ptr <= port_id_t'((int'(grant_port) + 1) % IF_N);
  end

  a_grant_has_slot: assert property (@(posedge clk) disable iff (rst_r)
    (desc_grant != '0) |-> (slot_counts[best_core] != '0));

endmodule

// File: src/slot_keeper.sv
// ----------------------------------------
// FIFO of free slot numbers for one core,
// filled by init and enqueue, drained by pop
// ----------------------------------------
`include "sched_defs.svh"

module slot_keeper (
  input  logic            clk,
  input  logic            rst_r,
  input  logic            flush,
  input  sched_pkg::slot_t init_count,
  input  logic            init_valid,
  input  sched_pkg::slot_t slot_in,
  input  logic            slot_in_valid,
  output sched_pkg::slot_t slot_out,
  output logic            slot_out_valid,
  input  logic            slot_pop,
  output sched_pkg::slot_t slot_count,
  output logic            enq_err
);
  import sched_pkg::*;

  localparam int DEPTH = `SCHED_SLOT_COUNT;
  localparam int AW    = $clog2(DEPTH);

  slot_t          mem [DEPTH];
  logic [AW-1:0]  rd_ptr;
  logic [AW-1:0]  wr_ptr;
  slot_t          count;
  logic           full;
  logic           do_enq;
  logic           do_pop;

  assign full   = (count == slot_t'(DEPTH));
  assign do_enq = slot_in_valid && !full;
  assign do_pop = slot_pop && (count != '0);

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      // Fresh list 1..init_count with the head at entry 0
      rd_ptr <= '0;
      wr_ptr <= init_count[AW-1:0];
      count  <= init_count;
    end else begin
      if (do_enq)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_enq && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_enq)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= slot_t'(i + 1);
    end else if (do_enq) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  assign slot_out       = mem[rd_ptr];
  assign slot_out_valid = (count != '0);
  assign slot_count     = count;
  // Returned slot dropped when the list is already full
  assign enq_err        = slot_in_valid && full;

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_r)
    slot_pop |-> (count != '0));

endmodule

// File: src/sched_pkg.sv
// ----------------------------------------
// Types shared by the scheduler modules
// ----------------------------------------
`include "sched_defs.svh"

package sched_pkg;

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0] core_id_t;
  typedef logic [`SCHED_CORE_COUNT-1:0] core_mask_t;
  typedef logic [`SCHED_IF_COUNT-1:0] port_mask_t;
  typedef logic [$clog2(`SCHED_IF_COUNT)-1:0] port_id_t;

  // Slots count from 1 so one extra bit is needed
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;

  // Core in the high bits above the zero-extended slot
  typedef logic [$bits(core_id_t)+`SCHED_TAG_WIDTH-1:0] desc_t;

  typedef logic [`SCHED_DATA_WIDTH-1:0] data_t;
  typedef logic [`SCHED_DATA_WIDTH/8-1:0] keep_t;
  typedef logic [`SCHED_CTRL_WIDTH-1:0] ctrl_t;
  typedef logic [31:0] host_word_t;

  typedef enum logic [1:0] {
    st_stall,
    st_first,
    st_wait_desc,
    st_mid
  } port_state_t;

endpackage

// File: src/sched_defs.svh
// ----------------------------------------
// Scheduler sizes, control message types and
// host register codes, included by the RTL
// ----------------------------------------
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

`define SCHED_IF_COUNT      2
`define SCHED_CORE_COUNT    4
`define SCHED_SLOT_COUNT    8
`define SCHED_DATA_WIDTH    64
`define SCHED_CTRL_WIDTH    36
`define SCHED_TAG_WIDTH     5

// Control message types in bits 35..32
`define SCHED_MSG_SLOT_ENQ  4'd0
`define SCHED_MSG_SLOT_INIT 4'd3

`define SCHED_REG_ENABLE    4'd0
`define SCHED_REG_INCOME    4'd1
`define SCHED_REG_FLUSH     4'd2
`define SCHED_REG_COUNT     4'd3
`define SCHED_RD_DEFAULT    32'hFEFEFEFE

`endif
